// ==== design/l1_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types of the L1 load-data array.
// Address widths, the request address union,
// the stored line and the lookup response.
////////////////////////////////////////////////////////////////////////////

package l1_pkg;

	// Word address of a request.
	localparam int ADDR_W = 16;
	localparam int IDX_W  = 6;               // 64 sets.
	localparam int TAG_W  = ADDR_W - IDX_W;  // 10 bits.
	localparam int DATA_W = 32;

	// Tag on top, set index below.
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] idx;
	} l1_addr_fields_t;

	// Request address, as a flat word or split into fields.
	typedef union packed {
		logic [ADDR_W-1:0] word;  // Raw word address.
		l1_addr_fields_t   fld;   // Tag and index view.
	} l1_addr_u;

	// One entry of a way, 43 bits.
	typedef struct packed {
		logic              valid;
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] data;
	} l1_line_t;

	// Lookup result at the top, 33 bits.
	typedef struct packed {
		logic              hit;   // Some way matched.
		logic [DATA_W-1:0] data;  // Zero on a miss.
	} l1_rsp_t;

endpackage

// ==== design/sram_sp.sv ====
////////////////////////////////////////////////////////////////////////////
// Single-port synchronous RAM.
// Write at the edge, registered read while enabled.
////////////////////////////////////////////////////////////////////////////

module sram_sp #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 64
) (
	input  logic                     CLK,
	input  logic                     en,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [WIDTH-1:0]         wdata,
	output logic [WIDTH-1:0]         rdata
);

	// Storage array, no reset like a macro.
	logic [WIDTH-1:0] mem [DEPTH];

	// Read returns the old word on a write cycle.
	always_ff @(posedge CLK) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;  // Write at the edge.
			end
			rdata <= mem[addr];  // One cycle read latency.
		end
	end

endmodule

// ==== design/l1_ld_mem.sv ====
////////////////////////////////////////////////////////////////////////////
// Memory wrapper with clear after reset.
// Walks every entry writing zeros, then raises ready
// and passes port accesses through to the RAM.
////////////////////////////////////////////////////////////////////////////

module l1_ld_mem #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 64
) (
	input  logic                     CLK,
	input  logic                     RST_N,
	input  logic                     en,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic                     we,
	input  logic [WIDTH-1:0]         wdata,
	output logic [WIDTH-1:0]         rdata,
	output logic                     ready
);

	localparam int AW = $clog2(DEPTH);
	localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);  // Terminal count.

	typedef enum logic {
		ST_CLEAR,
		ST_READY
	} state_t;

	state_t          state;
	logic [AW-1:0]   clr_addr;   // Entry being cleared.
	logic            clr_last;
	logic            mem_en;
	logic            mem_we;
	logic [AW-1:0]   mem_addr;
	logic [WIDTH-1:0] mem_wdata;

	assign clr_last = (clr_addr == LAST);

	// Clear FSM, one entry per cycle.
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state    <= ST_CLEAR;
			clr_addr <= '0;
		end else if (state == ST_CLEAR) begin
			if (clr_last) begin
				state <= ST_READY;  // Last entry written this edge.
			end else begin
				clr_addr <= clr_addr + 1'b1;
			end
		end
	end

	assign ready = (state == ST_READY);

	// Port is overridden until the clear is done.
	assign mem_en    = ready ? en : 1'b1;
	assign mem_we    = ready ? we : 1'b1;
	assign mem_addr  = ready ? addr : clr_addr;
	assign mem_wdata = ready ? wdata : '0;  // Zeros while clearing.

	sram_sp #(
		.WIDTH (WIDTH),
		.DEPTH (DEPTH)
	) u_ram (
		.CLK   (CLK),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (rdata)
	);

	// Port stays idle until the clear walk is done.
	a_idle_while_clear: assert property (@(posedge CLK) disable iff (!RST_N)
		!ready |-> !en);

endmodule

// ==== design/l1_req_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// Request decoder of the L1 load-data array.
// Splits the address, keeps the round-robin victim
// pointer and drives the enables of all ways.
////////////////////////////////////////////////////////////////////////////

module l1_req_decode #(
	parameter int WAYS = 4
) (
	input  logic                      CLK,
	input  logic                      RST_N,
	input  logic                      ready,
	input  logic                      req,
	input  logic                      fill,
	input  l1_pkg::l1_addr_u          addr,
	input  logic [l1_pkg::DATA_W-1:0] wdata,
	output logic [WAYS-1:0]           way_en,
	output logic [WAYS-1:0]           way_we,
	output logic [l1_pkg::IDX_W-1:0]  way_idx,
	output l1_pkg::l1_line_t          way_wline,
	output logic [l1_pkg::TAG_W-1:0]  lkp_tag,
	output logic                      lkp_go
);

	import l1_pkg::*;

	localparam int PTR_W = (WAYS > 1) ? $clog2(WAYS) : 1;

	l1_addr_fields_t  fld;         // Field view of the address.
	logic             acc;         // Request taken.
	logic             do_fill;
	logic             do_lkp;
	logic [PTR_W-1:0] vic_ptr;     // Round-robin victim.
	logic [WAYS-1:0]  vic_onehot;

	assign fld     = addr.fld;
	assign acc     = req && ready;  // Ignored until the clear is done.
	assign do_fill = acc && fill;
	assign do_lkp  = acc && !fill;

	assign vic_onehot = WAYS'(1) << vic_ptr;

	// All ways read on any request, only the victim is written.
	assign way_en  = {WAYS{acc}};
	assign way_we  = do_fill ? vic_onehot : '0;
	assign way_idx = fld.idx;

	// Fill line.
	always_comb begin
		way_wline.valid = 1'b1;
		way_wline.tag   = fld.tag;
		way_wline.data  = wdata;
	end

	// Victim pointer, advances after every fill whatever the set.
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			vic_ptr <= '0;
		end else if (do_fill) begin
			vic_ptr <= (vic_ptr == PTR_W'(WAYS - 1)) ? '0 : vic_ptr + 1'b1;
		end
	end

	// Lookup strobe, lines up with the RAM output.
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			lkp_go <= 1'b0;
		end else begin
			lkp_go <= do_lkp;
		end
	end

	always_ff @(posedge CLK) begin
		if (do_lkp) begin
			lkp_tag <= fld.tag;  // Tag to compare next cycle.
		end
	end

	// Caller waits for the ways to finish clearing.
	a_req_when_ready: assert property (@(posedge CLK) disable iff (!RST_N)
		req |-> ready);

endmodule

// ==== design/l1_way_select.sv ====
////////////////////////////////////////////////////////////////////////////
// Way selector of the L1 load-data array.
// Tag compare over all ways, hit data select
// and the registered lookup response.
////////////////////////////////////////////////////////////////////////////

module l1_way_select #(
	parameter int WAYS = 4
) (
	input  logic                             CLK,
	input  logic                             RST_N,
	input  l1_pkg::l1_line_t [WAYS-1:0]      way_rline,
	input  logic [l1_pkg::TAG_W-1:0]         lkp_tag,
	input  logic                             lkp_go,
	output logic                             rsp_valid,
	output l1_pkg::l1_rsp_t                  rsp
);

	import l1_pkg::*;

	logic [WAYS-1:0]   way_hit;   // Per way match.
	logic [DATA_W-1:0] hit_data;
	l1_rsp_t           rsp_d;     // Next response.

	// Valid and tag match per way, OR of the hitting data.
	always_comb begin
		hit_data = '0;
		for (int w = 0; w < WAYS; w++) begin
			way_hit[w] = way_rline[w].valid && (way_rline[w].tag == lkp_tag);
			hit_data   = hit_data | ({DATA_W{way_hit[w]}} & way_rline[w].data);
		end
		rsp_d.hit  = |way_hit;
		rsp_d.data = hit_data;  // Zero on a miss.
	end

	// Response register.
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rsp_valid <= 1'b0;
			rsp       <= '0;
		end else begin
			rsp_valid <= lkp_go;  // One cycle strobe per lookup.
			if (lkp_go) begin
				rsp <= rsp_d;
			end
		end
	end

	// A tag lives in at most one way of a set.
	// Two hits mean an address was filled twice.
	a_one_hit: assert property (@(posedge CLK) disable iff (!RST_N)
		lkp_go |-> $onehot0(way_hit));

endmodule

// ==== design/l1_ld_array.sv ====
////////////////////////////////////////////////////////////////////////////
// Top of the set-associative L1 load-data array.
// Request decoder, one cleared memory per way and the way selector.
////////////////////////////////////////////////////////////////////////////

module l1_ld_array #(
	parameter int WAYS = 4
) (
	input  logic                      CLK,
	input  logic                      RST_N,
	input  logic                      req,
	input  logic                      fill,
	input  l1_pkg::l1_addr_u          addr,
	input  logic [l1_pkg::DATA_W-1:0] wdata,
	output logic                      ready,
	output logic                      rsp_valid,
	output l1_pkg::l1_rsp_t           rsp
);

	import l1_pkg::*;

	localparam int LINE_W = $bits(l1_line_t);  // 43 bits.
	localparam int SETS   = 1 << IDX_W;

	logic [WAYS-1:0]      way_en;
	logic [WAYS-1:0]      way_we;
	logic [WAYS-1:0]      way_rdy;    // Clear done per way.
	logic [IDX_W-1:0]     way_idx;
	l1_line_t             way_wline;
	l1_line_t [WAYS-1:0]  way_rline;
	logic [TAG_W-1:0]     lkp_tag;
	logic                 lkp_go;

	assign ready = &way_rdy;  // All ways cleared.

	l1_req_decode #(
		.WAYS (WAYS)
	) u_decode (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.ready     (ready),
		.req       (req),
		.fill      (fill),
		.addr      (addr),
		.wdata     (wdata),
		.way_en    (way_en),
		.way_we    (way_we),
		.way_idx   (way_idx),
		.way_wline (way_wline),
		.lkp_tag   (lkp_tag),
		.lkp_go    (lkp_go)
	);

	// One memory per way.
	for (genvar w = 0; w < WAYS; w++) begin : g_way
		l1_ld_mem #(
			.WIDTH (LINE_W),
			.DEPTH (SETS)
		) u_mem (
			.CLK   (CLK),
			.RST_N (RST_N),
			.en    (way_en[w]),
			.addr  (way_idx),
			.we    (way_we[w]),
			.wdata (way_wline),
			.rdata (way_rline[w]),
			.ready (way_rdy[w])
		);
	end

	l1_way_select #(
		.WAYS (WAYS)
	) u_select (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.way_rline (way_rline),
		.lkp_tag   (lkp_tag),
		.lkp_go    (lkp_go),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

endmodule

// ==== testbench/tb_l1_ld_array.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench of the L1 load-data array.
// Clock, reset, LFSR stimulus, reference model of sets and ways,
// expected response queue and the checking assertions.
////////////////////////////////////////////////////////////////////////////

module tb_l1_ld_array;

	timeunit 1ns;
	timeprecision 1ps;

	import l1_pkg::*;

	localparam int WAYS    = 4;
	localparam int SETS    = 1 << IDX_W;
	localparam int CLR_CYC = 64;           // Clear walk of every way.
	localparam int N_MISS  = 24;           // Lookups into the empty array.
	localparam int N_PAIR  = 8;            // Fill, lookup, gap, lookup.
	localparam int N_EVICT = 19;           // Requests of the eviction test.
	localparam int N_MIX   = 200;
	localparam int N_REQS  = N_MISS + 3 * N_PAIR + N_EVICT + N_MIX;
	localparam int LIMIT   = 16 + CLR_CYC + 2 * N_REQS + 200;

	logic              CLK;
	logic              RST_N;
	logic              req;
	logic              fill;
	l1_addr_u          addr;
	logic [DATA_W-1:0] wdata;
	logic              ready;
	logic              rsp_valid;
	l1_rsp_t           rsp;

	// Reference model.
	logic              m_valid [SETS][WAYS];
	logic [TAG_W-1:0]  m_tag   [SETS][WAYS];
	logic [DATA_W-1:0] m_data  [SETS][WAYS];
	int                m_ptr = 0;            // Round-robin victim.
	l1_rsp_t           exp_q [$];            // Pending lookups, in order.
	l1_rsp_t           exp_rsp;              // Response due this cycle.
	logic [1:0]        pend;                 // Lookup in RAM read, at response.
	int                rel_cnt;              // Edges since reset release.
	int                cyc = 0;
	logic [15:0]       lfsr = 16'd24;

	l1_ld_array #(
		.WAYS (WAYS)
	) dut0 (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.req       (req),
		.fill      (fill),
		.addr      (addr),
		.wdata     (wdata),
		.ready     (ready),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic abort_run();
		$display("test failed");
		$fatal(1);
	endtask

	// Galois LFSR, taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Expected result of a lookup; data is zero on a miss.
	function automatic l1_rsp_t predict_lookup(input l1_addr_u a);
		l1_rsp_t r;
		r = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (m_valid[a.fld.idx][w] && m_tag[a.fld.idx][w] == a.fld.tag) begin
				r.hit  = 1'b1;
				r.data = m_data[a.fld.idx][w];
			end
		end
		return r;
	endfunction

	// Victim way takes the line, pointer moves on whatever the set.
	task automatic record_fill(input l1_addr_u a, input logic [DATA_W-1:0] d);
		m_valid[a.fld.idx][m_ptr] = 1'b1;
		m_tag[a.fld.idx][m_ptr]   = a.fld.tag;
		m_data[a.fld.idx][m_ptr]  = d;
		m_ptr = (m_ptr + 1) % WAYS;
	endtask

	task automatic send_req(input logic f, input l1_addr_u a, input logic [DATA_W-1:0] d);
		@(posedge CLK);
		req   <= 1'b1;
		fill  <= f;
		addr  <= a;
		wdata <= d;
		if (f) begin
			record_fill(a, d);
		end else begin
			exp_q.push_back(predict_lookup(a));  // Model state at request time.
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge CLK);
			req  <= 1'b0;
			fill <= 1'b0;
		end
	endtask

	// Lookup timing, response popped as it reaches the output.
	always @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pend    <= '0;
			rel_cnt <= 0;
			exp_rsp <= '0;
		end else begin
			rel_cnt <= rel_cnt + 1;
			pend    <= {pend[0], req && !fill};
			if (pend[0]) begin
				exp_rsp <= exp_q.pop_front();
			end
		end
	end

	always @(posedge CLK) begin
		cyc <= cyc + 1;
		if (cyc >= LIMIT) begin
			$display("Timeout, the run did not finish within %0d cycles", LIMIT);
			abort_run();
		end
	end

	a_ready: assert property (@(posedge CLK) disable iff (!RST_N)
		ready == (rel_cnt >= CLR_CYC))
		else begin
			$display("CHECK FAILED t=%0t ready expected %0b got %0b",
				$time, $sampled(rel_cnt) >= CLR_CYC, $sampled(ready));
			abort_run();
		end

	a_req_ready: assert property (@(posedge CLK) disable iff (!RST_N) req |-> ready)
		else begin
			$display("Request sent at t=%0t while ready was low", $time);
			abort_run();
		end

	// One strobe per lookup, none per fill.
	a_rsp_valid: assert property (@(posedge CLK) disable iff (!RST_N)
		rsp_valid == pend[1])
		else begin
			$display("CHECK FAILED t=%0t rsp_valid expected %0b got %0b",
				$time, $sampled(pend[1]), $sampled(rsp_valid));
			abort_run();
		end

	a_rsp_data: assert property (@(posedge CLK) disable iff (!RST_N)
		rsp_valid |-> (rsp == exp_rsp))
		else begin
			$display("CHECK FAILED t=%0t rsp expected %h got %h",
				$time, $sampled(exp_rsp), $sampled(rsp));
			abort_run();
		end

	a_rsp_reset: assert property (@(posedge CLK) disable iff (!RST_N)
		(rel_cnt <= CLR_CYC) |-> (rsp == '0))
		else begin
			$display("CHECK FAILED t=%0t rsp expected %h got %h",
				$time, '0, $sampled(rsp));
			abort_run();
		end

	initial begin
		l1_addr_u          a;
		l1_rsp_t           r;
		logic [DATA_W-1:0] d;
		logic [IDX_W-1:0]  i0;
		RST_N = 1'b0;
		req   = 1'b0;
		fill  = 1'b0;
		addr  = '0;
		wdata = '0;
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < WAYS; w++) begin
				m_valid[s][w] = 1'b0;
				m_tag[s][w]   = '0;
				m_data[s][w]  = '0;
			end
		end
		repeat (16) @(posedge CLK);
		RST_N <= 1'b1;
		while (!ready) @(posedge CLK);

		// Empty array, every lookup misses.
		for (int k = 0; k < N_MISS; k++) begin
			a.word = ADDR_W'(rand_bits(ADDR_W));
			send_req(1'b0, a, '0);
		end
		idle_cycles(4);

		// Fill then lookup on the next cycle and once more after a gap.
		for (int k = 0; k < N_PAIR; k++) begin
			a.word = ADDR_W'(rand_bits(ADDR_W));
			a.fld.tag[TAG_W-1] = 1'b0;  // Upper tag half kept for eviction test.
			r = predict_lookup(a);
			while (r.hit) begin
				a.fld.idx = a.fld.idx + 1'b1;
				r = predict_lookup(a);
			end
			d = rand_bits(DATA_W);
			send_req(1'b1, a, d);
			send_req(1'b0, a, '0);
			idle_cycles(1);
			send_req(1'b0, a, '0);
		end
		idle_cycles(4);

		// Five tags into one set, the first gets evicted.
		i0 = IDX_W'(rand_bits(IDX_W));
		a.fld.idx = i0;
		for (int k = 0; k < 5; k++) begin
			a.fld.tag = TAG_W'(512 + k);
			send_req(1'b1, a, rand_bits(DATA_W));
		end
		for (int k = 0; k < 5; k++) begin
			a.fld.tag = TAG_W'(512 + k);
			send_req(1'b0, a, '0);
		end
		// Fills elsewhere move the same pointer.
		a.fld.tag = TAG_W'(520);
		a.fld.idx = i0 + 1'b1;
		send_req(1'b1, a, rand_bits(DATA_W));
		a.fld.idx = i0 + 2'd2;
		send_req(1'b1, a, rand_bits(DATA_W));
		a.fld.idx = i0;
		a.fld.tag = TAG_W'(517);
		send_req(1'b1, a, rand_bits(DATA_W));
		for (int k = 0; k < 6; k++) begin
			a.fld.tag = TAG_W'(512 + k);
			send_req(1'b0, a, '0);
		end
		idle_cycles(4);

		// Mix over 8 sets and 8 tags, so hits and evictions are frequent.
		for (int k = 0; k < N_MIX; k++) begin
			a.word    = '0;
			a.fld.idx = IDX_W'(rand_bits(3));
			a.fld.tag = TAG_W'(rand_bits(3));
			if (rand_bits(2) == 0) begin
				r = predict_lookup(a);
				d = rand_bits(DATA_W);
				if (r.hit) begin
					send_req(1'b0, a, '0);  // Already cached, no second fill.
				end else begin
					send_req(1'b1, a, d);
				end
			end else begin
				send_req(1'b0, a, '0);
			end
			if (rand_bits(3) == 0) begin
				idle_cycles(1);
			end
		end
		idle_cycles(6);

		if (exp_q.size() != 0) begin
			$display("%0d lookups never got a response", exp_q.size());
			abort_run();
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

// ==== files.f ====
design/l1_pkg.sv
design/sram_sp.sv
design/l1_ld_mem.sv
design/l1_req_decode.sv
design/l1_way_select.sv
design/l1_ld_array.sv
testbench/tb_l1_ld_array.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the L1 load-data array testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_l1_ld_array \
	-f files.f \
	-o sim_tb

./obj_dir/sim_tb
